//--- common/arb_ifs.sv
`timescale 1ns/1ps

// request/grant handshake between the CRT line fetcher and the arbiter
interface crt_arb_if;
  logic crt_req;
  logic a_empty;
  logic b_empty;
  logic a_full_done;
  logic b_full_done;
  logic sync_crt_line_end;
  logic crt_gnt;

  modport fetch (
    output crt_req, a_empty, b_empty,
    output a_full_done, b_full_done, sync_crt_line_end,
    input  crt_gnt
  );

  modport arb (
    input  crt_req, a_empty, b_empty,
    input  a_full_done, b_full_done, sync_crt_line_end,
    output crt_gnt
  );
endinterface

// request/grant handshake between the APB port and the arbiter
interface cpu_arb_if;
  logic cpu_rd_req;
  logic cpu_wr_req;
  logic cpu_rd_gnt;
  logic cpu_wr_gnt;

  modport port (
    output cpu_rd_req, cpu_wr_req,
    input  cpu_rd_gnt, cpu_wr_gnt
  );

  modport arb (
    input  cpu_rd_req, cpu_wr_req,
    output cpu_rd_gnt, cpu_wr_gnt
  );
endinterface

//--- common/vga_mem_params.svh
`ifndef VGA_MEM_PARAMS_SVH
`define VGA_MEM_PARAMS_SVH

// ==============================
// video memory geometry
// ==============================

`define MEM_AW 12       // 4096 words of video memory
`define MEM_DW 16       // one character/attribute word

// ==============================
// display refill geometry
// ==============================

`define LINE_WORDS 16   // words fetched per display line
`define NUM_LINES  8    // lines per frame, the fetcher wraps after the last

`endif

//--- common/vga_mem_pkg.sv
`include "vga_mem_params.svh"

package vga_mem_pkg;

  // ==============================
  // datapath widths
  // ==============================

  typedef logic [`MEM_AW-1:0] mem_addr_t;              // word address into video memory
  typedef logic [`MEM_DW-1:0] mem_data_t;              // one memory word

  typedef logic [$clog2(`LINE_WORDS)-1:0] word_idx_t;  // word position within a line
  typedef logic [$clog2(`NUM_LINES)-1:0] line_idx_t;   // line number within the frame

  // ==============================
  // arbiter states
  // ==============================

  // code 1 is left unused
  typedef enum logic [2:0] {
    arb_idle     = 3'd0,  // no grant, waiting for a request
    arb_crt_pick = 3'd2,  // CRT won, choose the buffer to fill
    arb_cpu_wr   = 3'd3,  // CPU write granted
    arb_cpu_rd   = 3'd4,  // CPU read granted
    arb_crt_a    = 3'd5,  // CRT filling buffer A
    arb_crt_b    = 3'd6   // CRT filling buffer B
  } arb_state_t;

endpackage

//--- crt_fetch/crt_fetch.sv
`timescale 1ns/1ps
`include "vga_mem_params.svh"

module crt_fetch (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  crt_arb_if.fetch               arb,
  output vga_mem_pkg::mem_addr_t crt_addr,
  input  vga_mem_pkg::mem_data_t mem_rdata,
  input  logic                   crt_line_end,
  input  logic                   pix_rd,
  output logic                   pix_ready,
  output vga_mem_pkg::mem_data_t pix_data,
  output logic                   pix_valid
);
  import vga_mem_pkg::*;

  mem_data_t buf_a [`LINE_WORDS];
  mem_data_t buf_b [`LINE_WORDS];

  logic      a_full;
  logic      b_full;
  logic      disp_sel;      // 0 shows buffer A, 1 shows buffer B
  logic      disp_full;
  logic      fill_next;     // buffer the next fill goes to
  logic      fill_buf_q;    // buffer of the running fill
  logic      crt_req_q;
  line_idx_t line_idx;
  word_idx_t fetch_idx;
  word_idx_t wr_idx_q;
  word_idx_t rd_idx;
  logic      last_issued;
  logic      issue;
  logic      wr_en_q;
  logic      full_done;
  logic      pop;
  logic [2:0] le_sync;
  logic      line_end_q;

  // ==============================
  // fill order
  // ==============================

  // an empty display buffer must be filled first so lines stay in order
  assign disp_full = disp_sel ? b_full : a_full;
  assign fill_next = disp_full ? ~disp_sel : disp_sel;

  assign arb.a_empty = !a_full && !fill_next;   // empty and next in fill order
  assign arb.b_empty = !b_full && fill_next;
  assign arb.crt_req = crt_req_q;
  assign arb.sync_crt_line_end = line_end_q;

  assign full_done = wr_en_q && (wr_idx_q == word_idx_t'(`LINE_WORDS - 1));
  assign arb.a_full_done = full_done && !fill_buf_q;
  assign arb.b_full_done = full_done && fill_buf_q;

  assign issue = arb.crt_gnt && !last_issued;
  assign crt_addr = mem_addr_t'(line_idx * `LINE_WORDS + fetch_idx);

  assign pix_ready = disp_full;
  assign pop = pix_rd && pix_ready;               // reads without pix_ready are dropped

  // ==============================
  // refill control
  // ==============================

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      crt_req_q   <= 1'b0;
      fetch_idx   <= '0;
      last_issued <= 1'b0;
      wr_en_q     <= 1'b0;
      fill_buf_q  <= 1'b0;
      line_idx    <= '0;
      le_sync     <= '0;
      line_end_q  <= 1'b0;
    end else begin
      crt_req_q <= (arb.a_empty || arb.b_empty) && !arb.crt_gnt;
      wr_en_q   <= issue;
      if (!arb.crt_gnt) begin
        fetch_idx   <= '0;                        // aborted fills restart at word 0
        last_issued <= 1'b0;
        fill_buf_q  <= fill_next;
      end else if (issue) begin
        fetch_idx   <= fetch_idx + 1'b1;
        last_issued <= (fetch_idx == word_idx_t'(`LINE_WORDS - 1));
      end
      if (full_done) begin
        if (line_idx == line_idx_t'(`NUM_LINES - 1)) line_idx <= '0;
        else line_idx <= line_idx + 1'b1;
      end
      le_sync    <= {le_sync[1:0], crt_line_end};   // two sync flops plus edge history
      line_end_q <= le_sync[1] && !le_sync[2];
    end
  end

  // ==============================
  // buffer state and pixel port
  // ==============================

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      a_full    <= 1'b0;
      b_full    <= 1'b0;
      disp_sel  <= 1'b0;
      rd_idx    <= '0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= pop;
      if (line_end_q && !disp_sel) a_full <= 1'b0;  // display releases its buffer
      if (line_end_q && disp_sel) b_full <= 1'b0;
      if (arb.a_full_done) a_full <= 1'b1;
      if (arb.b_full_done) b_full <= 1'b1;
      if (line_end_q) begin
        disp_sel <= ~disp_sel;
        rd_idx   <= '0;
      end else if (pop) begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge mem_clk) begin
    wr_idx_q <= fetch_idx;                          // memory returns data one cycle later
    if (wr_en_q && !fill_buf_q) buf_a[wr_idx_q] <= mem_rdata;
    if (wr_en_q && fill_buf_q) buf_b[wr_idx_q] <= mem_rdata;
    if (pop) pix_data <= disp_sel ? buf_b[rd_idx] : buf_a[rd_idx];
  end

endmodule

//--- dv/tb_vga_mem_top.sv
`timescale 1ns/1ps
`include "vga_mem_params.svh"

module tb_vga_mem_top;
  import vga_mem_pkg::*;

  localparam int TIMEOUT = 500;   // cycles allowed for any single wait

  logic      mem_clk;
  logic      hreset_n;
  mem_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  mem_data_t pwdata;
  mem_data_t prdata;
  logic      pready;
  logic      crt_line_end;
  logic      pix_rd;
  logic      pix_ready;
  logic      pix_valid;
  mem_data_t pix_data;

  logic [31:0] lfsr;
  mem_data_t   model [mem_addr_t];   // expected video memory contents
  mem_addr_t   written_q [$];
  int          exp_line;             // line the display buffer should hold

  vga_mem_top UUT (
    .mem_clk      (mem_clk),
    .hreset_n     (hreset_n),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .crt_line_end (crt_line_end),
    .pix_rd       (pix_rd),
    .pix_ready    (pix_ready),
    .pix_valid    (pix_valid),
    .pix_data     (pix_data)
  );

  initial begin
    mem_clk = 1'b0;
    forever #50 mem_clk = ~mem_clk;
  end

  // ==============================
  // helpers and checks
  // ==============================

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
    if (got !== exp) fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr[0];
      lfsr = lfsr >> 1;
      if (out_bit) lfsr = lfsr ^ 32'hb4bcd35c;
      val = {val[30:0], out_bit};
    end
    return val;
  endfunction

  task automatic wait_pix_ready();
    int count;
    count = 0;
    @(negedge mem_clk);
    while (!pix_ready) begin
      check_flag("pready", pready, 1'b0);   // no APB transfer runs here
      if (count >= TIMEOUT) fail_run("timeout waiting for pix_ready after a buffer fill");
      else begin
        count++;
        @(negedge mem_clk);
      end
    end
  endtask

  task automatic wait_pready();
    int count;
    count = 0;
    @(negedge mem_clk);
    while (!pready) begin
      if (count >= TIMEOUT) fail_run("timeout waiting for pready to end an APB transfer");
      else begin
        count++;
        @(negedge mem_clk);
      end
    end
  endtask

  // ==============================
  // APB and pixel drivers
  // ==============================

  task automatic apb_access(input mem_addr_t addr, input logic write, input mem_data_t wdata,
                            output mem_data_t rdata);
    @(posedge mem_clk);
    paddr   <= addr;
    pwdata  <= wdata;
    pwrite  <= write;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge mem_clk);
    penable <= 1'b1;
    wait_pready();
    rdata = prdata;                  // sampled mid-cycle while pready is high
    @(posedge mem_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_and_record(input mem_addr_t addr, input mem_data_t data);
    mem_data_t unused;
    apb_access(addr, 1'b1, data, unused);
    if (!model.exists(addr)) written_q.push_back(addr);
    model[addr] = data;
  endtask

  task automatic read_pixel(output mem_data_t data);
    int count;
    count = 0;
    @(posedge mem_clk);
    pix_rd <= 1'b1;
    @(negedge mem_clk);
    check_flag("pix_valid", pix_valid, 1'b0);   // pix_valid only follows a pop
    @(posedge mem_clk);
    pix_rd <= 1'b0;
    @(negedge mem_clk);
    while (!pix_valid) begin
      if (count >= TIMEOUT) fail_run("timeout waiting for pix_valid after a pixel read");
      else begin
        count++;
        @(negedge mem_clk);
      end
    end
    data = pix_data;
  endtask

  // the strobe needs 3 cycles through the synchronizer, then the buffers swap
  task automatic pulse_line_end();
    @(posedge mem_clk);
    crt_line_end <= 1'b1;
    @(posedge mem_clk);
    crt_line_end <= 1'b0;
    repeat (4) @(posedge mem_clk);
    exp_line = (exp_line + 1) % `NUM_LINES;
  endtask

  task automatic show_line(input int nwords);
    mem_data_t data;
    mem_addr_t addr;
    wait_pix_ready();
    for (int k = 0; k < nwords; k++) begin
      read_pixel(data);
      addr = mem_addr_t'(exp_line * `LINE_WORDS + k);
      check_data($sformatf("pix_data line %0d word %0d", exp_line, k), data, model[addr]);
    end
    pulse_line_end();
  endtask

  // ==============================
  // test sequence
  // ==============================

  initial begin
    mem_addr_t addr;
    mem_data_t data;
    int        idx;
    lfsr = 32'h61a4;
    exp_line = 0;
    hreset_n     <= 1'b0;
    paddr        <= '0;
    psel         <= 1'b0;
    penable      <= 1'b0;
    pwrite       <= 1'b0;
    pwdata       <= '0;
    crt_line_end <= 1'b0;
    pix_rd       <= 1'b0;
    repeat (8) @(posedge mem_clk);
    hreset_n <= 1'b1;
    @(negedge mem_clk);
    check_flag("pix_ready", pix_ready, 1'b0);
    check_flag("pready", pready, 1'b0);
    wait_pix_ready();                       // first fill of buffer A
    for (int i = 0; i < `NUM_LINES * `LINE_WORDS; i++) begin
      write_and_record(mem_addr_t'(i), mem_data_t'(rand_bits(16)));
    end
    for (int i = 0; i < 48; i++) begin
      addr = mem_addr_t'(rand_bits(`MEM_AW));
      write_and_record(addr, mem_data_t'(rand_bits(16)));
    end
    // line ends in between make the CRT side refill while reads wait
    for (int i = 0; i < 60; i++) begin
      if (i % 12 == 3) begin
        wait_pix_ready();
        pulse_line_end();
      end
      idx = int'(rand_bits(10)) % written_q.size();
      addr = written_q[idx];
      apb_access(addr, 1'b0, '0, data);
      check_data($sformatf("prdata at 0x%h", addr), data, model[addr]);
    end
    for (int i = 0; i < 10; i++) begin
      show_line(`LINE_WORDS);
    end
    for (int i = 0; i < 12; i++) begin
      show_line(1 + int'(rand_bits(4)) % (`LINE_WORDS - 1));
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- list.f
+incdir+common
common/vga_mem_pkg.sv
common/arb_ifs.sv
verilog/sm_arb.sv
crt_fetch/crt_fetch.sv
verilog/cpu_apb_port.sv
verilog/video_mem.sv
verilog/vga_mem_top.sv
dv/tb_vga_mem_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench, the exit status reports pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary -f list.f --top-module tb_vga_mem_top -o tb_vga_mem_top

./obj_dir/tb_vga_mem_top

//--- verilog/cpu_apb_port.sv
`timescale 1ns/1ps

module cpu_apb_port (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  input  vga_mem_pkg::mem_addr_t paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  vga_mem_pkg::mem_data_t pwdata,
  output vga_mem_pkg::mem_data_t prdata,
  output logic                   pready,
  cpu_arb_if.port                arb,
  output vga_mem_pkg::mem_addr_t cpu_addr,
  output vga_mem_pkg::mem_data_t cpu_wdata,
  input  vga_mem_pkg::mem_data_t mem_rdata
);
  import vga_mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,    // waiting for an APB access phase
    st_req,     // request raised, waiting for the grant
    st_data,    // read data on its way out of the memory
    st_done     // pready, request already dropped
  } port_state_t;

  port_state_t state_q;
  port_state_t state_d;
  mem_addr_t   addr_q;
  mem_data_t   wdata_q;
  logic        write_q;
  logic        gnt;

  assign gnt = write_q ? arb.cpu_wr_gnt : arb.cpu_rd_gnt;

  // ==============================
  // transfer FSM
  // ==============================

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (psel && penable) state_d = st_req;
      end
      st_req: begin
        if (gnt) state_d = write_q ? st_done : st_data;   // write lands on the grant edge
      end
      st_data: state_d = st_done;
      st_done: state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  // a read keeps its request through st_data so the grant holds the address
  assign arb.cpu_wr_req = write_q && (state_q == st_req);
  assign arb.cpu_rd_req = !write_q && ((state_q == st_req) || (state_q == st_data));
  assign pready = (state_q == st_done);

  assign cpu_addr  = addr_q;
  assign cpu_wdata = wdata_q;

  // APB holds address and data stable, capture them while idle
  always_ff @(posedge mem_clk) begin
    if (state_q == st_idle) begin
      addr_q  <= paddr;
      wdata_q <= pwdata;
      write_q <= pwrite;
    end
    if (state_q == st_data) prdata <= mem_rdata;
  end

endmodule

//--- verilog/sm_arb.sv
`timescale 1ns/1ps

module sm_arb (
  input logic    mem_clk,
  input logic    hreset_n,
  crt_arb_if.arb crt,
  cpu_arb_if.arb cpu
);
  import vga_mem_pkg::*;

  arb_state_t state_q;
  arb_state_t state_d;

  // ==============================
  // state register
  // ==============================

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      state_q <= arb_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ==============================
  // next state
  // ==============================

  always_comb begin
    state_d = state_q;
    case (state_q)
      arb_idle: begin
        if (crt.crt_req) state_d = arb_crt_pick;           // CRT refill has top priority
        else if (cpu.cpu_wr_req) state_d = arb_cpu_wr;
        else if (cpu.cpu_rd_req) state_d = arb_cpu_rd;
      end
      arb_crt_pick: begin
        if (crt.a_empty) state_d = arb_crt_a;
        else if (crt.b_empty) state_d = arb_crt_b;
        else state_d = arb_idle;                            // both buffers already full
      end
      arb_cpu_wr: begin
        if (!cpu.cpu_wr_req) state_d = arb_idle;
      end
      arb_cpu_rd: begin
        if (!cpu.cpu_rd_req) state_d = arb_idle;
      end
      arb_crt_a: begin
        if (crt.a_full_done || crt.sync_crt_line_end) state_d = arb_idle;
      end
      arb_crt_b: begin
        if (crt.b_full_done || crt.sync_crt_line_end) state_d = arb_idle;
      end
      default: state_d = arb_idle;
    endcase
  end

  // grants come straight from the registered state, so they never glitch
  always_comb begin
    crt.crt_gnt    = 1'b0;
    cpu.cpu_wr_gnt = 1'b0;
    cpu.cpu_rd_gnt = 1'b0;
    case (state_q)
      arb_crt_a, arb_crt_b: crt.crt_gnt = 1'b1;
      arb_cpu_wr: cpu.cpu_wr_gnt = 1'b1;
      arb_cpu_rd: cpu.cpu_rd_gnt = 1'b1;
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/vga_mem_top.sv
`timescale 1ns/1ps

module vga_mem_top (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  input  vga_mem_pkg::mem_addr_t paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  vga_mem_pkg::mem_data_t pwdata,
  output vga_mem_pkg::mem_data_t prdata,
  output logic                   pready,
  input  logic                   crt_line_end,
  input  logic                   pix_rd,
  output logic                   pix_ready,
  output logic                   pix_valid,
  output vga_mem_pkg::mem_data_t pix_data
);
  import vga_mem_pkg::*;

  mem_addr_t crt_addr;
  mem_addr_t cpu_addr;
  mem_data_t cpu_wdata;
  mem_data_t mem_rdata;   // shared by the fetcher and the APB port

  crt_arb_if crt_if ();
  cpu_arb_if cpu_if ();

  sm_arb u_arb (
    .mem_clk  (mem_clk),
    .hreset_n (hreset_n),
    .crt      (crt_if.arb),
    .cpu      (cpu_if.arb)
  );

  crt_fetch u_crt_fetch (
    .mem_clk      (mem_clk),
    .hreset_n     (hreset_n),
    .arb          (crt_if.fetch),
    .crt_addr     (crt_addr),
    .mem_rdata    (mem_rdata),
    .crt_line_end (crt_line_end),
    .pix_rd       (pix_rd),
    .pix_ready    (pix_ready),
    .pix_data     (pix_data),
    .pix_valid    (pix_valid)
  );

  cpu_apb_port u_cpu_port (
    .mem_clk   (mem_clk),
    .hreset_n  (hreset_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .arb       (cpu_if.port),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .mem_rdata (mem_rdata)
  );

  video_mem u_video_mem (
    .mem_clk    (mem_clk),
    .crt_gnt    (crt_if.crt_gnt),
    .cpu_wr_gnt (cpu_if.cpu_wr_gnt),
    .cpu_rd_gnt (cpu_if.cpu_rd_gnt),
    .crt_addr   (crt_addr),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .mem_rdata  (mem_rdata)
  );

endmodule

//--- verilog/video_mem.sv
`timescale 1ns/1ps
`include "vga_mem_params.svh"

module video_mem (
  input  logic                   mem_clk,
  input  logic                   crt_gnt,
  input  logic                   cpu_wr_gnt,
  input  logic                   cpu_rd_gnt,
  input  vga_mem_pkg::mem_addr_t crt_addr,
  input  vga_mem_pkg::mem_addr_t cpu_addr,
  input  vga_mem_pkg::mem_data_t cpu_wdata,
  output vga_mem_pkg::mem_data_t mem_rdata
);
  import vga_mem_pkg::*;

  mem_data_t mem [2**`MEM_AW];
  mem_addr_t addr;
  logic      rd_en;

  // ==============================
  // port select
  // ==============================

  // grants are exclusive, the CRT side owns the address only under its grant
  assign addr  = crt_gnt ? crt_addr : cpu_addr;
  assign rd_en = crt_gnt || cpu_rd_gnt;   // idle cycles leave the read register alone

  // ==============================
  // storage
  // ==============================

  always_ff @(posedge mem_clk) begin
    if (cpu_wr_gnt) begin
      mem[addr] <= cpu_wdata;
    end
    if (rd_en) begin
      mem_rdata <= mem[addr];             // data follows the address by one cycle
    end
  end

endmodule
